// File: source/cpu_pkg.sv
package cpu_pkg;

  // Bus widths
  typedef logic [7:0]  data_t;
  typedef logic [15:0] addr_t;

  // Supported subset of the SM83 opcode map
  typedef enum logic [7:0] {
    NOP       = 8'h00,
    LD_B_N8   = 8'h06,
    JR_NZ_E8  = 8'h20,
    LD_HL_N16 = 8'h21,
    INC_HL    = 8'h23,
    JR_Z_E8   = 8'h28,
    INC_A     = 8'h3C,
    LD_A_N8   = 8'h3E,
    HALT      = 8'h76,
    LD_HLM_A  = 8'h77,
    ADD_A_B   = 8'h80,
    SUB_A_B   = 8'h90,
    AND_A_B   = 8'hA0,
    XOR_A_B   = 8'hA8,
    JP_N16    = 8'hC3,
    PUSH_AF   = 8'hF5
  } opcode_t;

  // Clock phase within a machine cycle
  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  // Bus action of one machine cycle
  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;

  // 16-bit register pairs where WZ holds fetched operands
  typedef enum logic [1:0] {ADDR_PC, ADDR_HL, ADDR_SP, ADDR_WZ} addr_src_t;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_A,
    REG_B,
    REG_H,
    REG_L,
    REG_W,
    REG_Z,
    REG_F
  } reg_sel_t;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_INC
  } alu_op_t;

  // REL adds the signed byte held in Z
  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC, IDU_REL} idu_op_t;

  typedef enum logic [1:0] {COND_NONE, COND_NZ, COND_Z} cond_t;

  // Flag positions in F with the low nibble always zero
  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  localparam addr_t PC_RESET = 16'h0000;
  localparam addr_t SP_RESET = 16'hFFFE;

  // Longest instruction including the opcode fetch
  localparam int MAX_MCYCLES = 4;

endpackage

// File: source/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::data_t        rdata,
  input  logic                  cond_ok,
  output cpu_pkg::t_phase_t     phase,
  output cpu_pkg::bus_op_t      bus_op,
  output cpu_pkg::addr_src_t    addr_src,
  output cpu_pkg::reg_sel_t     load_dst,
  output cpu_pkg::reg_sel_t     alu_dst,
  output cpu_pkg::reg_sel_t     wr_src,
  output cpu_pkg::alu_op_t      alu_op,
  output cpu_pkg::idu_op_t      idu_op,
  output cpu_pkg::addr_src_t    idu_target,
  output cpu_pkg::cond_t        cond,
  output logic                  req_read,
  output logic                  req_write,
  output logic                  halted,
  output logic                  illegal
);
  import cpu_pkg::*;

  logic [$clog2(MAX_MCYCLES)-1:0] mcycle;   // Machine cycle within the instruction
  logic [$clog2(MAX_MCYCLES)-1:0] last_mc;  // Index of the final machine cycle
  data_t ir;
  logic  bad_op;
  logic  cond_fail;

  assign cond_fail = (cond != COND_NONE) && !cond_ok;

  // Microcode lookup
  // In cycle 0 the IR only becomes valid at T4, so only ALU fields depend on it there
  always_comb begin
    bus_op     = BUS_NONE;
    addr_src   = ADDR_PC;
    load_dst   = REG_NONE;
    wr_src     = REG_NONE;
    alu_op     = ALU_NONE;
    alu_dst    = REG_NONE;
    idu_op     = IDU_NONE;
    idu_target = ADDR_PC;
    cond       = COND_NONE;
    last_mc    = 0;
    bad_op     = 1'b0;

    if (mcycle == 0) begin
      bus_op = BUS_READ;  // Opcode fetch from PC
      idu_op = IDU_INC;
    end

    case (ir)
      NOP, HALT: last_mc = 0;
      INC_A: begin
        alu_op  = ALU_INC;
        alu_dst = REG_A;
      end
      ADD_A_B: begin
        alu_op  = ALU_ADD;
        alu_dst = REG_A;
      end
      SUB_A_B: begin
        alu_op  = ALU_SUB;
        alu_dst = REG_A;
      end
      AND_A_B: begin
        alu_op  = ALU_AND;
        alu_dst = REG_A;
      end
      XOR_A_B: begin
        alu_op  = ALU_XOR;
        alu_dst = REG_A;
      end
      LD_B_N8, LD_A_N8: begin
        last_mc = 1;
        if (mcycle == 1) begin
          bus_op   = BUS_READ;
          idu_op   = IDU_INC;
          load_dst = (ir == LD_B_N8) ? REG_B : REG_A;
        end
      end
      LD_HL_N16: begin
        last_mc = 2;
        if (mcycle != 0) begin
          bus_op   = BUS_READ;
          idu_op   = IDU_INC;
          load_dst = (mcycle == 1) ? REG_L : REG_H;  // Little endian
        end
      end
      INC_HL: begin
        last_mc = 1;
        if (mcycle == 1) begin
          idu_op     = IDU_INC;
          idu_target = ADDR_HL;
        end
      end
      LD_HLM_A: begin
        last_mc = 1;
        if (mcycle == 1) begin
          bus_op   = BUS_WRITE;
          addr_src = ADDR_HL;
          wr_src   = REG_A;
        end
      end
      JP_N16: begin
        last_mc = 3;
        if (mcycle == 1 || mcycle == 2) begin
          bus_op   = BUS_READ;
          idu_op   = IDU_INC;
          load_dst = (mcycle == 1) ? REG_Z : REG_W;
        end else if (mcycle == 3) begin
          idu_target = ADDR_WZ;  // PC takes the fetched target
        end
      end
      JR_NZ_E8, JR_Z_E8: begin
        last_mc = 2;
        if (mcycle == 1) begin
          bus_op   = BUS_READ;
          idu_op   = IDU_INC;
          load_dst = REG_Z;
          cond     = (ir == JR_Z_E8) ? COND_Z : COND_NZ;
        end else if (mcycle == 2) begin
          idu_op = IDU_REL;
        end
      end
      PUSH_AF: begin
        last_mc = 3;
        if (mcycle == 1) begin
          idu_op     = IDU_DEC;
          idu_target = ADDR_SP;
        end else if (mcycle != 0) begin
          bus_op     = BUS_WRITE;
          addr_src   = ADDR_SP;
          wr_src     = (mcycle == 2) ? REG_A : REG_F;
          idu_op     = (mcycle == 2) ? IDU_DEC : IDU_NONE;
          idu_target = ADDR_SP;
        end
      end
      default: bad_op = 1'b1;
    endcase
  end

  // Phase and machine-cycle sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= T1;
      mcycle    <= '0;
      ir        <= NOP;
      req_read  <= 1'b0;
      req_write <= 1'b0;
      halted    <= 1'b0;
      illegal   <= 1'b0;
    end else if (!halted) begin
      case (phase)
        T1: phase <= T2;
        T2: begin
          phase     <= T3;
          req_read  <= (bus_op == BUS_READ);
          req_write <= (bus_op == BUS_WRITE);
        end
        T3: begin
          phase <= T4;
          if (mcycle == 0) ir <= rdata;
        end
        default: begin
          phase     <= T1;
          req_read  <= 1'b0;
          req_write <= 1'b0;
          if (mcycle == 0 && (bad_op || ir == HALT)) begin
            halted  <= 1'b1;
            illegal <= bad_op;
          end
          if (mcycle == last_mc || cond_fail) mcycle <= '0;
          else mcycle <= mcycle + 1'b1;
        end
      endcase
    end
  end

  a_req_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_read && req_write) && (!(req_read || req_write) || phase == T3 || phase == T4));

  a_mcycle_max: assert property (@(posedge clk) disable iff (reset) mcycle <= last_mc);

endmodule

// File: source/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
  input  cpu_pkg::alu_op_t alu_op,
  input  cpu_pkg::data_t   a_val,
  input  cpu_pkg::data_t   b_val,
  input  cpu_pkg::data_t   flags,
  input  cpu_pkg::idu_op_t idu_op,
  input  cpu_pkg::addr_t   idu_in,
  input  cpu_pkg::data_t   z_val,
  input  cpu_pkg::cond_t   cond,
  output cpu_pkg::data_t   alu_result,
  output cpu_pkg::data_t   alu_flags,
  output cpu_pkg::addr_t   idu_result,
  output logic             cond_ok
);
  import cpu_pkg::*;

  logic [4:0] nib;   // Low nibble with carry or borrow out
  logic [8:0] full;  // Whole byte with carry or borrow out

  always_comb begin
    nib        = '0;
    full       = '0;
    alu_result = a_val;
    alu_flags  = flags;  // NONE leaves F as it is

    case (alu_op)
      ALU_ADD: begin
        nib  = {1'b0, a_val[3:0]} + {1'b0, b_val[3:0]};
        full = {1'b0, a_val} + {1'b0, b_val};
        alu_result        = full[7:0];
        alu_flags[FLAG_N] = 1'b0;
        alu_flags[FLAG_H] = nib[4];
        alu_flags[FLAG_C] = full[8];
      end
      ALU_SUB: begin
        nib  = {1'b0, a_val[3:0]} - {1'b0, b_val[3:0]};
        full = {1'b0, a_val} - {1'b0, b_val};
        alu_result        = full[7:0];
        alu_flags[FLAG_N] = 1'b1;
        alu_flags[FLAG_H] = nib[4];   // Borrow from bit 4
        alu_flags[FLAG_C] = full[8];
      end
      ALU_AND: begin
        alu_result        = a_val & b_val;
        alu_flags[FLAG_N] = 1'b0;
        alu_flags[FLAG_H] = 1'b1;
        alu_flags[FLAG_C] = 1'b0;
      end
      ALU_XOR: begin
        alu_result        = a_val ^ b_val;
        alu_flags[FLAG_N] = 1'b0;
        alu_flags[FLAG_H] = 1'b0;
        alu_flags[FLAG_C] = 1'b0;
      end
      ALU_INC: begin
        nib        = {1'b0, a_val[3:0]} + 5'd1;
        alu_result = a_val + 8'd1;
        alu_flags[FLAG_N] = 1'b0;
        alu_flags[FLAG_H] = nib[4];   // C is kept
      end
      default: ;
    endcase

    if (alu_op != ALU_NONE) alu_flags[FLAG_Z] = (alu_result == 8'h00);
  end

  // 16-bit incrementer and relative adder
  always_comb begin
    case (idu_op)
      IDU_INC: idu_result = idu_in + 16'd1;
      IDU_DEC: idu_result = idu_in - 16'd1;
      IDU_REL: idu_result = idu_in + {{8{z_val[7]}}, z_val};  // Signed offset
      default: idu_result = idu_in;
    endcase
  end

  always_comb begin
    case (cond)
      COND_NZ: cond_ok = !flags[FLAG_Z];
      COND_Z:  cond_ok = flags[FLAG_Z];
      default: cond_ok = 1'b1;
    endcase
  end

  // F passes through here, so this also covers the stored flags
  always_comb begin
    a_flags_low: assert (alu_flags[3:0] == 4'h0);
  end

endmodule

// File: source/cpu_result.sv
`timescale 1ns/1ps

module cpu_result (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::t_phase_t   phase,
  input  cpu_pkg::data_t      rdata,
  input  cpu_pkg::reg_sel_t   load_dst,
  input  cpu_pkg::alu_op_t    alu_op,
  input  cpu_pkg::reg_sel_t   alu_dst,
  input  cpu_pkg::data_t      alu_result,
  input  cpu_pkg::data_t      alu_flags,
  input  cpu_pkg::idu_op_t    idu_op,
  input  cpu_pkg::addr_src_t  idu_target,
  input  cpu_pkg::addr_t      idu_result,
  input  cpu_pkg::addr_src_t  addr_src,
  input  cpu_pkg::reg_sel_t   wr_src,
  output cpu_pkg::addr_t      addr,
  output cpu_pkg::data_t      wdata,
  output cpu_pkg::data_t      a_val,
  output cpu_pkg::data_t      b_val,
  output cpu_pkg::data_t      flags,
  output cpu_pkg::data_t      z_val,
  output cpu_pkg::addr_t      idu_in
);
  import cpu_pkg::*;

  data_t a, b, h, l, f;
  data_t w, z;          // Operand temporaries
  addr_t pc, sp;
  data_t wr_byte;

  function automatic addr_t pair_sel(addr_src_t sel, addr_t pc_v, addr_t hl_v,
                                     addr_t sp_v, addr_t wz_v);
    case (sel)
      ADDR_HL: return hl_v;
      ADDR_SP: return sp_v;
      ADDR_WZ: return wz_v;
      default: return pc_v;
    endcase
  endfunction

  assign idu_in = pair_sel(idu_target, pc, {h, l}, sp, {w, z});
  assign a_val  = a;
  assign b_val  = b;
  assign flags  = f;
  assign z_val  = z;

  always_comb begin
    case (wr_src)
      REG_A:   wr_byte = a;
      REG_B:   wr_byte = b;
      REG_H:   wr_byte = h;
      REG_L:   wr_byte = l;
      REG_W:   wr_byte = w;
      REG_Z:   wr_byte = z;
      REG_F:   wr_byte = f;
      default: wr_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= PC_RESET;
      sp <= SP_RESET;
      a  <= '0;
      b  <= '0;
      h  <= '0;
      l  <= '0;
      f  <= '0;
    end else if (phase == T3) begin
      case (load_dst)  // Read data lands at the end of T3
        REG_A: a <= rdata;
        REG_B: b <= rdata;
        REG_H: h <= rdata;
        REG_L: l <= rdata;
        default: ;
      endcase
    end else if (phase == T4) begin
      if (alu_op != ALU_NONE) begin
        f <= alu_flags;
        if (alu_dst == REG_A) a <= alu_result;
        else if (alu_dst == REG_B) b <= alu_result;
      end
      if (idu_target == ADDR_WZ) pc <= idu_result;  // Jump target
      else if (idu_op != IDU_NONE) begin
        case (idu_target)
          ADDR_HL: {h, l} <= idu_result;
          ADDR_SP: sp <= idu_result;
          default: pc <= idu_result;
        endcase
      end
    end
  end

  // Operand temporaries and bus registers
  always_ff @(posedge clk) begin
    if (phase == T1) addr <= pair_sel(addr_src, pc, {h, l}, sp, {w, z});
    if (phase == T2 && wr_src != REG_NONE) wdata <= wr_byte;
    if (phase == T3 && load_dst == REG_W) w <= rdata;
    if (phase == T3 && load_dst == REG_Z) z <= rdata;
  end

  a_pc_t4: assert property (@(posedge clk) disable iff (reset)
    (pc != $past(pc)) |-> ($past(phase) == T4));

endmodule

// File: source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::data_t rdata,
  output cpu_pkg::addr_t addr,
  output cpu_pkg::data_t wdata,
  output logic           req_read,
  output logic           req_write,
  output logic           halted,
  output logic           illegal
);
  import cpu_pkg::*;

  // Control word of the current machine cycle
  t_phase_t  phase;
  bus_op_t   bus_op;
  addr_src_t addr_src;
  addr_src_t idu_target;
  reg_sel_t  load_dst;
  reg_sel_t  alu_dst;
  reg_sel_t  wr_src;
  alu_op_t   alu_op;
  idu_op_t   idu_op;
  cond_t     cond;
  logic      cond_ok;

  // Datapath between execute and result
  data_t a_val, b_val, flags, z_val;
  data_t alu_result, alu_flags;
  addr_t idu_in, idu_result;

  cpu_decode i_decode (
    .clk, .reset, .rdata, .cond_ok,
    .phase, .bus_op, .addr_src,
    .load_dst, .alu_dst, .wr_src,
    .alu_op, .idu_op, .idu_target, .cond,
    .req_read, .req_write, .halted, .illegal
  );

  cpu_execute i_execute (
    .alu_op, .a_val, .b_val, .flags,
    .idu_op, .idu_in, .z_val, .cond,
    .alu_result, .alu_flags, .idu_result, .cond_ok
  );

  cpu_result i_result (
    .clk, .reset, .phase, .rdata,
    .load_dst, .alu_op, .alu_dst, .alu_result, .alu_flags,
    .idu_op, .idu_target, .idu_result,
    .addr_src, .wr_src,
    .addr, .wdata,
    .a_val, .b_val, .flags, .z_val, .idu_in
  );

endmodule

// File: verif/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
  import cpu_pkg::*;

  localparam string CASE_FILE    = "verif/cpu_cases.txt";
  localparam int    RESET_CYCLES = 16;
  localparam int    HALT_WATCH   = 8;  // Clocks of bus silence watched after halt

  logic  clk = 1'b0;
  logic  reset;
  data_t rdata;
  addr_t addr;
  data_t wdata;
  logic  req_read;
  logic  req_write;
  logic  halted;
  logic  illegal;

  data_t mem [0:65535];

  // Parsed cases index into the flat queues
  string case_name [$];
  int    case_mem_lo [$];
  int    case_mem_hi [$];
  int    case_exp_lo [$];
  int    case_exp_hi [$];
  logic  case_illegal [$];
  addr_t mem_addr_q [$];
  data_t mem_byte_q [$];
  addr_t exp_addr_q [$];
  data_t exp_data_q [$];

  addr_t wr_addr_q [$];   // Writes seen in the running case
  data_t wr_data_q [$];
  logic  write_prev = 1'b0;

  int value_errs  = 0;
  int other_errs  = 0;
  int cycles      = 0;
  int cycle_limit = 0;

  always #5 clk = ~clk;

  cpu_core i_dut (
    .clk, .reset, .rdata,
    .addr, .wdata, .req_read, .req_write, .halted, .illegal
  );

  // Memory answers in the same cycle
  assign rdata = (req_read === 1'b1) ? mem[addr] : 8'h00;

  // Write monitor sampling away from the active edge
  always @(negedge clk) begin
    if (req_write && !write_prev) begin
      wr_addr_q.push_back(addr);
      wr_data_q.push_back(wdata);
    end
    if (halted && (req_read || req_write)) begin
      $display("Bus request at address %h while the core is halted", addr);
      other_errs++;
    end
    write_prev = req_write;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d clocks, the core never halted", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_addr(string name, addr_t expected, addr_t actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      value_errs++;
    end
  endtask

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      value_errs++;
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %b, actual %b", name, expected, actual);
      value_errs++;
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    flag;
    string tok;
    string rest;
    addr_t cur;
    addr_t a;
    data_t d;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CASE_FILE);
      other_errs++;
      return;
    end
    cur = '0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        void'($fgets(rest, fd));
      end else if (tok == "case") begin
        void'($fscanf(fd, "%s", tok));
        case_name.push_back(tok);
        case_mem_lo.push_back(mem_addr_q.size());
        case_exp_lo.push_back(exp_addr_q.size());
      end else if (tok == "mem") begin
        void'($fscanf(fd, "%h", cur));
      end else if (tok == "exp") begin
        void'($fscanf(fd, "%h %h", a, d));
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
      end else if (tok == "end") begin
        void'($fscanf(fd, "%d", flag));
        case_illegal.push_back(flag != 0);
        case_mem_hi.push_back(mem_addr_q.size());
        case_exp_hi.push_back(exp_addr_q.size());
      end else begin
        mem_addr_q.push_back(cur);  // Program byte following a mem address
        mem_byte_q.push_back(data_t'(tok.atohex()));
        cur++;
      end
    end
    $fclose(fd);
  endtask

  // 64 clocks per program byte plus 200 per case
  function automatic int timeout_limit();
    int total;
    total = 0;
    foreach (case_name[c]) total += 64 * (case_mem_hi[c] - case_mem_lo[c]) + 200;
    return total;
  endfunction

  task automatic run_case(int c);
    string name;
    int    lo;
    int    n_exp;
    name  = case_name[c];
    lo    = case_exp_lo[c];
    n_exp = case_exp_hi[c] - lo;
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 65536; i++) mem[i] = data_t'(i >> 8) ^ data_t'(i) ^ 8'hA5;
    for (int i = case_mem_lo[c]; i < case_mem_hi[c]; i++) mem[mem_addr_q[i]] = mem_byte_q[i];
    repeat (RESET_CYCLES) @(posedge clk);
    wr_addr_q.delete();
    wr_data_q.delete();
    reset <= 1'b0;
    while (halted !== 1'b1) @(posedge clk);
    repeat (HALT_WATCH) @(posedge clk);

    for (int i = 0; i < n_exp; i++) begin
      if (i < wr_addr_q.size()) begin
        check_addr($sformatf("%s write %0d address", name, i), exp_addr_q[lo + i], wr_addr_q[i]);
        check_data($sformatf("%s write %0d data", name, i), exp_data_q[lo + i], wr_data_q[i]);
      end else begin
        $display("%s: expected write %0d to %h never happened", name, i, exp_addr_q[lo + i]);
        other_errs++;
      end
    end
    for (int i = n_exp; i < wr_addr_q.size(); i++) begin
      $display("%s: unexpected write of %h to %h", name, wr_data_q[i], wr_addr_q[i]);
      other_errs++;
    end
    check_flag({name, " halted"}, 1'b1, halted);
    check_flag({name, " illegal"}, case_illegal[c], illegal);
  endtask

  initial begin
    reset = 1'b1;
    load_cases();
    if (case_name.size() == 0 || case_illegal.size() != case_name.size()) begin
      $display("The case file holds no complete cases");
      other_errs++;
    end else begin
      cycle_limit = timeout_limit();
      foreach (case_name[c]) run_case(c);
    end

    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb.f
source/cpu_pkg.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/cpu_core.sv
verif/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module cpu_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcpu_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  exit 0
fi
exit 1

// File: verif/cpu_cases.txt
# case <name> / mem <start address> <bytes...> / exp <write address> <write data>
# end <expected illegal flag>; exp records are listed in bus write order
case load_store
mem 0000 21 FF C0 3E 5A 77 23 77 76 77
exp C0FF 5A
exp C100 5A
end 0
case alu_add_xor_and
mem 0000 3E F0 06 10 80 F5 A8 F5 3E 0F A0 F5 76
exp FFFD 00
exp FFFC 90
exp FFFB 10
exp FFFA 00
exp FFF9 00
exp FFF8 A0
end 0
case alu_sub_inc
mem 0000 3E 01 06 02 90 F5 3C F5 76
exp FFFD FF
exp FFFC 70
exp FFFB 00
exp FFFA B0
end 0
case jp_far
mem 0000 C3 00 80 77 76
mem 8000 21 34 12 3E 77 77 76
exp 1234 77
end 0
case jr_z_fwd_taken
mem 0000 21 00 C0 A8 28 04 3E 01 77 76 3E 02 77 76
exp C000 02
end 0
case jr_z_fwd_skip
mem 0000 21 00 C0 3C 28 04 3E 01 77 76 3E 02 77 76
exp C000 01
end 0
case jr_nz_fwd_skip
mem 0000 21 00 C0 A8 20 04 3E 01 77 76 3E 02 77 76
exp C000 01
end 0
case jr_nz_back_loop
mem 0000 21 00 C0 3E FD 77 23 3C 20 FB 76
exp C000 FD
exp C001 FE
exp C002 FF
end 0
case jr_z_back
mem 0000 C3 10 00 3E 02 77 76
mem 0010 A8 21 00 C0 28 ED 3E 01 77 76
exp C000 02
end 0
case illegal_op
mem 0000 21 00 C0 3E 42 D3 77 76
end 1
